// ==== flist.f ====
source/la_isa_pkg.sv
source/fetch_pkg.sv
source/pre_decoder.sv
source/fetch_pc_counter.sv
source/fetch_ctrl.sv
source/axil_fetch_master.sv
source/fetch_fifo.sv
source/fetch_frontend.sv
tests/fetch_frontend_props.sv
tests/tb_fetch_frontend.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_fetch_frontend \
    -f flist.f -o tb_fetch_frontend > sim.log 2>&1 &&
    ./obj_dir/tb_fetch_frontend >> sim.log 2>&1 ||
    { echo "build or simulation error, see sim.log"; exit 1; }
grep -q "Result: FAILED" sim.log && { echo "FAIL, see sim.log"; exit 1; }
echo "PASS"
exit 0

// ==== source/axil_fetch_master.sv ====
module axil_fetch_master import fetch_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        pair_start,
    input  logic [31:0] fetch_pc,
    output axil_ar_t    ar,
    input  logic        arready,
    input  axil_r_t     r,
    output logic        rready,
    output logic        pair_done,
    output fetch_pair_t pair,
    output logic        master_idle
);

    typedef enum logic [1:0] {
        M_IDLE,
        M_AR,
        M_R,
        M_DONE
    } mstate_e;

    mstate_e     state;
    // 0 while reading inst0, 1 for inst1
    logic        word_sel;
    logic [31:0] base_addr;

    assign base_addr = {pair.pc[31:3], 3'b000};

    // address held from the latched pc, stable until arready
    always_comb begin
        ar.arvalid = (state == M_AR);
        ar.araddr  = word_sel ? base_addr + WORD_BYTES : base_addr;
        ar.arprot  = ARPROT_INSN;
    end

    assign rready      = (state == M_R);
    assign pair_done   = (state == M_DONE);
    assign master_idle = (state == M_IDLE);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= M_IDLE;
            word_sel <= 1'b0;
        end else begin
            case (state)
                M_IDLE: begin
                    if (pair_start) begin
                        state    <= M_AR;
                        word_sel <= 1'b0;
                    end
                end
                M_AR: begin
                    if (arready) begin
                        state <= M_R;
                    end
                end
                M_R: begin
                    if (r.rvalid) begin
                        state    <= word_sel ? M_DONE : M_AR;
                        word_sel <= ~word_sel;
                    end
                end
                default: state <= M_IDLE;
            endcase
        end
    end

    // pair payload
    always_ff @(posedge clk) begin
        if (master_idle && pair_start) begin
            pair.pc <= fetch_pc;
        end
        if (rready && r.rvalid) begin
            if (word_sel) begin
                pair.inst1 <= r.rdata;
            end else begin
                pair.inst0 <= r.rdata;
            end
        end
    end

endmodule

// ==== source/fetch_ctrl.sv ====
module fetch_ctrl (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       redirect_valid,
    input  logic       pair_done,
    input  logic       fifo_has_room,
    input  logic       master_idle,
    input  logic [1:0] priv_flag,
    output logic       pair_start,
    output logic       pair_discard,
    output logic       flush
);

    typedef enum logic [1:0] {
        S_RUN,
        S_WAIT,
        S_HOLD,
        S_DRAIN
    } state_e;

    state_e state;
    state_e state_nxt;

    // no start on a redirect cycle, the pc is being reloaded
    assign pair_start = (state == S_RUN) && fifo_has_room && master_idle && !redirect_valid;

    // a pair completing alongside a redirect is stale too
    assign pair_discard = (state == S_DRAIN) || redirect_valid;
    assign flush        = redirect_valid;

    always_comb begin
        state_nxt = state;
        case (state)
            S_RUN: begin
                if (pair_start) begin
                    state_nxt = S_WAIT;
                end
            end
            S_WAIT: begin
                if (redirect_valid) begin
                    state_nxt = pair_done ? S_RUN : S_DRAIN;
                end else if (pair_done) begin
                    // serialise behind any privileged op
                    state_nxt = (priv_flag != 2'b00) ? S_HOLD : S_RUN;
                end
            end
            S_HOLD: begin
                if (redirect_valid) begin
                    state_nxt = S_RUN;
                end
            end
            S_DRAIN: begin
                if (pair_done) begin
                    state_nxt = S_RUN;
                end
            end
            default: state_nxt = S_RUN;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= S_RUN;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

// ==== source/fetch_fifo.sv ====
module fetch_fifo import fetch_pkg::*; #(
    parameter int DEPTH = PKT_FIFO_DEPTH
) (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          flush,
    input  logic          push,
    input  fetch_packet_t push_data,
    output logic          has_room,
    output logic          pop_valid,
    input  logic          pop_ready,
    output fetch_packet_t pop_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    fetch_packet_t    mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // a free slot is what the next pair will land in
    assign has_room  = (count < CNT_W'(DEPTH));
    assign pop_valid = (count != '0);
    assign pop_data  = mem[rd_ptr];

    assign do_push = push && has_room;
    assign do_pop  = pop_valid && pop_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

// ==== source/fetch_frontend.sv ====
module fetch_frontend import la_isa_pkg::*, fetch_pkg::*; (
    input  logic          clk,
    input  logic          arst_n,
    // AXI4-Lite read master
    output axil_ar_t      ar,
    input  logic          arready,
    input  axil_r_t       r,
    output logic          rready,
    // back-end redirect
    input  logic          redirect_valid,
    input  logic [31:0]   redirect_pc,
    // to decode
    output logic          packet_valid,
    output fetch_packet_t packet,
    input  logic          packet_ready
);

    logic        pair_start;
    logic        pair_discard;
    logic        pair_done;
    logic        flush;
    logic        fifo_has_room;
    logic        master_idle;
    logic        fifo_push;
    logic [31:0] fetch_pc;
    fetch_pair_t pair;
    predecode_t  predecode;

    assign fifo_push = pair_done && !pair_discard;

    fetch_ctrl fetch_ctrl_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .redirect_valid (redirect_valid),
        .pair_done      (pair_done),
        .fifo_has_room  (fifo_has_room),
        .master_idle    (master_idle),
        .priv_flag      (predecode.priv_flag),
        .pair_start     (pair_start),
        .pair_discard   (pair_discard),
        .flush          (flush)
    );

    fetch_pc_counter fetch_pc_counter_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .pair_start     (pair_start),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .fetch_pc       (fetch_pc)
    );

    axil_fetch_master axil_fetch_master_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .pair_start  (pair_start),
        .fetch_pc    (fetch_pc),
        .ar          (ar),
        .arready     (arready),
        .r           (r),
        .rready      (rready),
        .pair_done   (pair_done),
        .pair        (pair),
        .master_idle (master_idle)
    );

    pre_decoder pre_decoder_i (
        .pair      (pair),
        .predecode (predecode)
    );

    fetch_fifo #(
        .DEPTH (PKT_FIFO_DEPTH)
    ) fetch_fifo_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .push      (fifo_push),
        .push_data ({pair, predecode}),
        .has_room  (fifo_has_room),
        .pop_valid (packet_valid),
        .pop_ready (packet_ready),
        .pop_data  (packet)
    );

endmodule

// ==== source/fetch_pc_counter.sv ====
module fetch_pc_counter import fetch_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        pair_start,
    input  logic        redirect_valid,
    input  logic [31:0] redirect_pc,
    output logic [31:0] fetch_pc
);

    logic [31:0] next_pair_pc;

    // drop the upper-word offset before stepping to the next pair
    assign next_pair_pc = {fetch_pc[31:3], 1'b0, fetch_pc[1:0]} + PAIR_BYTES;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_pc <= RESET_PC;
        end else if (redirect_valid) begin
            fetch_pc <= redirect_pc;
        end else if (pair_start) begin
            fetch_pc <= next_pair_pc;
        end
    end

endmodule

// ==== source/fetch_pkg.sv ====
package fetch_pkg;
    import la_isa_pkg::*;

    // first pair fetched after reset
    localparam logic [31:0] RESET_PC = 32'h1C00_0000;

    localparam int PKT_FIFO_DEPTH = 4;

    // byte distance between pairs and between the two words of a pair
    localparam logic [31:0] PAIR_BYTES = 32'd8;
    localparam logic [31:0] WORD_BYTES = 32'd4;

    // instruction access, unprivileged, secure
    localparam logic [2:0] ARPROT_INSN = 3'b100;

    // AXI4-Lite read address channel, master side
    typedef struct packed {
        logic        arvalid;
        logic [31:0] araddr;
        logic [2:0]  arprot;
    } axil_ar_t;

    // AXI4-Lite read data channel, slave side
    typedef struct packed {
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_r_t;

    // one fetched pair; pc may have bit 2 set after a redirect
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst0;
        logic [31:0] inst1;
    } fetch_pair_t;

    // what decode receives
    typedef struct packed {
        fetch_pair_t pair;
        predecode_t  predecode;
    } fetch_packet_t;

endpackage

// ==== source/la_isa_pkg.sv ====
package la_isa_pkg;

    // branch kind of one instruction word
    typedef enum logic [1:0] {
        BT_NONE     = 2'b00,
        BT_UNCOND   = 2'b01,
        BT_PCREL    = 2'b10,
        BT_INDIRECT = 2'b11
    } btype_e;

    // major opcode, bits 31..26
    localparam logic [5:0] OP_BEQZ = 6'b010000;
    localparam logic [5:0] OP_BNEZ = 6'b010001;
    localparam logic [5:0] OP_JIRL = 6'b010011;
    localparam logic [5:0] OP_B    = 6'b010100;
    localparam logic [5:0] OP_BL   = 6'b010101;
    // beq .. bgeu form one contiguous range
    localparam logic [5:0] OP_BEQ  = 6'b010110;
    localparam logic [5:0] OP_BGEU = 6'b011011;

    // ibar, bits 31..27, needs bit 15 set as well
    localparam logic [4:0] OP_IBAR_HI = 5'b00111;

    // csr group, bits 31..24; rj of zero is a plain csrrd
    localparam logic [7:0] OP_CSR = 8'b00000100;

    // tlb maintenance
    localparam logic [31:0] INSN_TLBSRCH = 32'h0648_2800;
    localparam logic [31:0] INSN_TLBRD   = 32'h0648_2C00;
    // invtlb prefix, bits 31..15
    localparam logic [16:0] OP_INVTLB    = 17'b0000011_0010010011;

    // per-pair tags, bit 1 of each flag belongs to inst1
    typedef struct packed {
        logic [1:0]       priv_flag;
        logic [1:0]       ibar_flag;
        logic [1:0]       csr_flag;
        logic [1:0]       tlb_flag;
        btype_e [1:0]     branch_flag;
        btype_e           inst_btype;
        logic             inst_bpos;
    } predecode_t;

endpackage

// ==== source/pre_decoder.sv ====
module pre_decoder import la_isa_pkg::*, fetch_pkg::*; (
    input  fetch_pair_t pair,
    output predecode_t  predecode
);

    function automatic logic is_ibar(input logic [31:0] insn);
        return (insn[31:27] == OP_IBAR_HI) && insn[15];
    endfunction

    // csrwr and csrxchg only, csrrd has rj == 0
    function automatic logic is_csr_write(input logic [31:0] insn);
        return (insn[31:24] == OP_CSR) && (insn[9:5] != 5'd0);
    endfunction

    function automatic logic is_tlb(input logic [31:0] insn);
        return (insn == INSN_TLBSRCH) || (insn == INSN_TLBRD) ||
               (insn[31:15] == OP_INVTLB);
    endfunction

    function automatic btype_e classify_branch(input logic [31:0] insn);
        logic [5:0] op;
        op = insn[31:26];
        if (op == OP_B || op == OP_BL) begin
            return BT_UNCOND;
        end
        if (op == OP_BEQZ || op == OP_BNEZ || (op >= OP_BEQ && op <= OP_BGEU)) begin
            return BT_PCREL;
        end
        if (op == OP_JIRL) begin
            return BT_INDIRECT;
        end
        return BT_NONE;
    endfunction

    logic [1:0] ibar;
    logic [1:0] csr;
    logic [1:0] tlb;
    btype_e     bt0;
    btype_e     bt1;

    always_comb begin
        ibar = {is_ibar(pair.inst1), is_ibar(pair.inst0)};
        csr  = {is_csr_write(pair.inst1), is_csr_write(pair.inst0)};
        tlb  = {is_tlb(pair.inst1), is_tlb(pair.inst0)};
        bt0  = classify_branch(pair.inst0);
        bt1  = classify_branch(pair.inst1);

        // entry at the upper word, inst0 is not part of the stream
        if (pair.pc[2]) begin
            ibar[0] = 1'b0;
            csr[0]  = 1'b0;
            tlb[0]  = 1'b0;
            bt0     = BT_NONE;
        end

        predecode.ibar_flag      = ibar;
        predecode.csr_flag       = csr;
        predecode.tlb_flag       = tlb;
        predecode.priv_flag      = ibar | csr | tlb;
        predecode.branch_flag[0] = bt0;
        predecode.branch_flag[1] = bt1;
        // the later slot wins when both branch
        predecode.inst_btype     = (bt1 != BT_NONE) ? bt1 : bt0;
        predecode.inst_bpos      = (bt0 == BT_NONE);
    end

endmodule

// ==== tests/fetch_frontend_props.sv ====
module fetch_frontend_props import fetch_pkg::*; (
    input logic          clk,
    input logic          arst_n,
    input axil_ar_t      ar,
    input logic          arready,
    input axil_r_t       r,
    input logic          rready,
    input logic          redirect_valid,
    input logic          packet_valid,
    input fetch_packet_t packet,
    input logic          packet_ready
);

    // reads accepted on AR and not yet answered on R
    logic [1:0] outstanding;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            outstanding <= '0;
        end else begin
            outstanding <= outstanding + 2'(ar.arvalid && arready) - 2'(r.rvalid && rready);
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (!arst_n)
        ar.arvalid && !arready |=> ar.arvalid && $stable(ar.araddr) && $stable(ar.arprot))
        else $error("AR channel changed before arready");

    one_read: assert property (@(posedge clk) disable iff (!arst_n)
        ar.arvalid |-> outstanding == 2'd0)
        else $error("second read issued while one is outstanding");

    // a flush may legally drop the head packet
    packet_hold: assert property (@(posedge clk) disable iff (!arst_n)
        packet_valid && !packet_ready && !redirect_valid |=> packet_valid && $stable(packet))
        else $error("packet changed while stalled");

    reset_low: assert property (@(posedge clk)
        !arst_n |-> !ar.arvalid && !rready && !packet_valid)
        else $error("outputs active during reset");

endmodule

bind fetch_frontend fetch_frontend_props fetch_frontend_props_i (
    .clk            (clk),
    .arst_n         (arst_n),
    .ar             (ar),
    .arready        (arready),
    .r              (r),
    .rready         (rready),
    .redirect_valid (redirect_valid),
    .packet_valid   (packet_valid),
    .packet         (packet),
    .packet_ready   (packet_ready)
);

// ==== tests/tb_fetch_frontend.sv ====
module tb_fetch_frontend
    import la_isa_pkg::*, fetch_pkg::*;
();

    localparam logic [31:0] TAB_BASE  = 32'h1C00_0100;
    localparam logic [31:0] PRIV_BASE = 32'h1C00_0200;
    localparam logic [31:0] BP_BASE   = 32'h1C00_0400;
    localparam logic [31:0] MID_BASE  = 32'h1C00_0600;
    localparam int          N_TAGS    = 10;
    localparam int          WAIT_MAX  = 400;

    // hand-decoded meaning of one instruction word
    typedef struct packed {
        logic [31:0] word;
        btype_e      kind;
        logic        ibar;
        logic        csr;
        logic        tlb;
    } insn_tag_t;

    logic          clk = 1'b0;
    logic          arst_n = 1'b0;
    axil_ar_t      ar;
    logic          arready = 1'b0;
    axil_r_t       r = '0;
    logic          rready;
    logic          redirect_valid;
    logic [31:0]   redirect_pc;
    logic          packet_valid;
    fetch_packet_t packet;
    logic          packet_ready;

    insn_tag_t     tags [N_TAGS];
    logic [31:0]   imem [logic [31:0]];
    int            errors = 0;
    int            tests_run = 0;
    int            tests_failed = 0;

    // memory model state
    logic [1:0]    ar_delay = 2'd0;
    logic [1:0]    r_delay = 2'd0;
    logic          r_pending = 1'b0;
    logic [31:0]   r_addr = '0;

    fetch_frontend fetch_frontend_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .ar             (ar),
        .arready        (arready),
        .r              (r),
        .rready         (rready),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .packet_valid   (packet_valid),
        .packet         (packet),
        .packet_ready   (packet_ready)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    // plain addi.w whose immediate folds in every address bit
    function automatic logic [31:0] filler_word(input logic [31:0] addr);
        logic [31:0] h;
        h = addr ^ (addr >> 10) ^ (addr >> 20);
        return {10'b0000001010, h[21:0]};
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        if (imem.exists(addr)) begin
            return imem[addr];
        end
        return filler_word(addr);
    endfunction

    function automatic insn_tag_t tag_of(input logic [31:0] word);
        insn_tag_t t;
        int        i;
        t = '0;
        for (i = 0; i < N_TAGS; i++) begin
            if (tags[i].word == word) begin
                t = tags[i];
            end
        end
        return t;
    endfunction

    function automatic fetch_packet_t expect_packet(input logic [31:0] pc);
        fetch_packet_t p;
        insn_tag_t     t0;
        insn_tag_t     t1;
        p = '0;
        p.pair.pc    = pc;
        p.pair.inst0 = mem_word({pc[31:3], 3'b000});
        p.pair.inst1 = mem_word({pc[31:3], 3'b100});
        // entry at the upper word drops inst0
        t0 = pc[2] ? '0 : tag_of(p.pair.inst0);
        t1 = tag_of(p.pair.inst1);
        p.predecode.ibar_flag      = {t1.ibar, t0.ibar};
        p.predecode.csr_flag       = {t1.csr, t0.csr};
        p.predecode.tlb_flag       = {t1.tlb, t0.tlb};
        p.predecode.priv_flag      = {t1.ibar | t1.csr | t1.tlb, t0.ibar | t0.csr | t0.tlb};
        p.predecode.branch_flag[0] = t0.kind;
        p.predecode.branch_flag[1] = t1.kind;
        p.predecode.inst_btype     = (t1.kind != BT_NONE) ? t1.kind : t0.kind;
        p.predecode.inst_bpos      = (t0.kind == BT_NONE);
        return p;
    endfunction

    // AXI4-Lite slave with 0 to 3 wait cycles on each channel
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            arready   <= 1'b0;
            r         <= '0;
            r_pending <= 1'b0;
        end else begin
            if (ar.arvalid && arready) begin
                arready   <= 1'b0;
                r_pending <= 1'b1;
                r_addr    <= ar.araddr;
                r_delay   <= 2'($urandom_range(3, 0));
            end else if (ar.arvalid) begin
                if (ar_delay == 2'd0) begin
                    arready  <= 1'b1;
                    ar_delay <= 2'($urandom_range(3, 0));
                end else begin
                    ar_delay <= ar_delay - 2'd1;
                end
            end
            if (r.rvalid && rready) begin
                r.rvalid <= 1'b0;
            end else if (r_pending && !r.rvalid) begin
                if (r_delay == 2'd0) begin
                    r.rvalid  <= 1'b1;
                    r.rdata   <= mem_word(r_addr);
                    r.rresp   <= 2'b00;
                    r_pending <= 1'b0;
                end else begin
                    r_delay <= r_delay - 2'd1;
                end
            end
        end
    end

    // one-cycle pulse starting at the edge just passed
    task automatic redirect_to(input logic [31:0] target);
        redirect_valid <= 1'b1;
        redirect_pc    <= target;
        @(posedge clk);
        redirect_valid <= 1'b0;
    endtask

    task automatic check_next_packet(input logic [31:0] pc);
        fetch_packet_t exp;
        logic          seen;
        int            n;
        exp  = expect_packet(pc);
        seen = 1'b0;
        for (n = 0; n < WAIT_MAX && !seen; n++) begin
            @(posedge clk);
            seen = packet_valid && packet_ready;
        end
        if (!seen) begin
            $display("timeout at %0t, no packet for pc %h", $time, pc);
            errors++;
        end else begin
            assert (packet.pair == exp.pair) else begin
                $display("error %0t packet.pair got %h expected %h", $time, packet.pair, exp.pair);
                errors++;
            end
            assert (packet.predecode == exp.predecode) else begin
                $display("error %0t packet.predecode got %h expected %h",
                         $time, packet.predecode, exp.predecode);
                errors++;
            end
        end
    endtask

    task automatic close_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed, %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        int   mark;
        int   n;
        int   starts;
        int   idle;
        logic seen;
        void'($urandom(82059));
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        packet_ready   = 1'b1;
        tags[0] = '{32'h5000_0400, BT_UNCOND, 1'b0, 1'b0, 1'b0};   // b
        tags[1] = '{32'h5400_0800, BT_UNCOND, 1'b0, 1'b0, 1'b0};   // bl
        tags[2] = '{32'h5800_0C85, BT_PCREL, 1'b0, 1'b0, 1'b0};    // beq
        tags[3] = '{32'h4000_1020, BT_PCREL, 1'b0, 1'b0, 1'b0};    // beqz
        tags[4] = '{32'h4C00_0020, BT_INDIRECT, 1'b0, 1'b0, 1'b0}; // jirl
        tags[5] = '{32'h3872_8000, BT_NONE, 1'b1, 1'b0, 1'b0};     // ibar
        tags[6] = '{32'h0400_1824, BT_NONE, 1'b0, 1'b1, 1'b0};     // csrwr
        tags[7] = '{32'h0400_1804, BT_NONE, 1'b0, 1'b0, 1'b0};     // csrrd
        tags[8] = '{32'h0648_2800, BT_NONE, 1'b0, 1'b0, 1'b1};     // tlbsrch
        tags[9] = '{32'h0649_8000, BT_NONE, 1'b0, 1'b0, 1'b1};     // invtlb
        // each word once in slot 0 and once in slot 1
        for (n = 0; n < N_TAGS; n++) begin
            imem[TAB_BASE + 32'(8 * n)]     = tags[n].word;
            imem[TAB_BASE + 32'(8 * n + 4)] = tags[(n + 1) % N_TAGS].word;
        end
        imem[PRIV_BASE + 32'h4] = tags[5].word;
        imem[PRIV_BASE + 32'h8] = tags[6].word;
        imem[PRIV_BASE + 32'hC] = tags[0].word;

        mark = errors;
        repeat (3) begin
            @(posedge clk);
            assert (!ar.arvalid && !rready && !packet_valid) else begin
                $display("error %0t {arvalid,rready,packet_valid} got %b expected 000",
                         $time, {ar.arvalid, rready, packet_valid});
                errors++;
            end
        end
        arst_n <= 1'b1;
        seen = 1'b0;
        for (n = 0; n < WAIT_MAX && !seen; n++) begin
            @(posedge clk);
            seen = ar.arvalid;
        end
        if (!seen) begin
            $display("timeout at %0t, no read after reset", $time);
            errors++;
        end else begin
            assert (ar.araddr == RESET_PC) else begin
                $display("error %0t ar.araddr got %h expected %h", $time, ar.araddr, RESET_PC);
                errors++;
            end
            // AxPROT bit 2 marks an instruction access
            assert (ar.arprot[2]) else begin
                $display("error %0t ar.arprot[2] got %b expected 1", $time, ar.arprot[2]);
                errors++;
            end
        end
        close_test("reset", mark);

        mark = errors;
        for (n = 0; n < 6; n++) begin
            check_next_packet(RESET_PC + 32'(8 * n));
        end
        close_test("sequential", mark);

        mark = errors;
        for (n = 0; n < N_TAGS; n++) begin
            redirect_to(TAB_BASE + 32'(8 * n));
            check_next_packet(TAB_BASE + 32'(8 * n));
        end
        close_test("predecode table", mark);

        mark = errors;
        redirect_to(PRIV_BASE);
        check_next_packet(PRIV_BASE);
        for (n = 0; n < 50; n++) begin
            @(posedge clk);
            assert (!ar.arvalid) else begin
                $display("error %0t ar.arvalid got %b expected 0 after a privileged pair",
                         $time, ar.arvalid);
                errors++;
            end
        end
        redirect_to(PRIV_BASE + 32'hC);
        check_next_packet(PRIV_BASE + 32'hC);
        close_test("privileged hold", mark);

        mark = errors;
        packet_ready <= 1'b0;
        redirect_to(BP_BASE);
        starts = 0;
        idle   = 0;
        for (n = 0; n < WAIT_MAX && idle < 30; n++) begin
            @(posedge clk);
            if (ar.arvalid && arready && !ar.araddr[2] && ar.araddr[31:8] == BP_BASE[31:8]) begin
                starts++;
            end
            idle = ar.arvalid ? 0 : idle + 1;
        end
        if (idle < 30) begin
            $display("timeout at %0t, fetch never stopped under back-pressure", $time);
            errors++;
        end
        assert (starts >= 1 && starts <= PKT_FIFO_DEPTH) else begin
            $display("error %0t pair starts got %0d expected 1 to %0d",
                     $time, starts, PKT_FIFO_DEPTH);
            errors++;
        end
        packet_ready <= 1'b1;
        for (n = 0; n < starts + 2; n++) begin
            check_next_packet(BP_BASE + 32'(8 * n));
        end
        close_test("back-pressure", mark);

        mark = errors;
        seen = 1'b0;
        // second word of a pair on the bus
        for (n = 0; n < WAIT_MAX && !seen; n++) begin
            @(posedge clk);
            seen = ar.arvalid && ar.araddr[2];
        end
        if (!seen) begin
            $display("timeout at %0t, no read in flight to interrupt", $time);
            errors++;
        end
        redirect_to(MID_BASE);
        check_next_packet(MID_BASE);
        close_test("redirect mid-read", mark);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
